//--- source/videoPkg.sv
/*
 Shared types for the video transmit path. Timing fields are raw counter
 values; the configuration must be static while rstN is high.
*/
`default_nettype none

package videoPkg;

	// Counter widths for the raster position
	localparam int hWidth = 11;
	localparam int vWidth = 11;

	// RGB444 pixel, red in the top nibble
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgbPixel;

	// Display timing register set
	typedef struct packed {
		logic [hWidth-1:0] hDisplay;
		logic [hWidth-1:0] hSyncStart;
		logic [hWidth-1:0] hSyncEnd;
		logic [hWidth-1:0] hMax;
		logic [vWidth-1:0] vDisplay;
		logic [vWidth-1:0] vSyncStart;
		logic [vWidth-1:0] vSyncEnd;
		logic [vWidth-1:0] vMax;
	} videoTiming;

	// TFT pin bundle
	typedef struct packed {
		logic [3:0] colorR;
		logic [3:0] colorG;
		logic [3:0] colorB;
		logic       hSync;
		logic       vSync;
		logic       de;
		logic       backLight;
	} tftPins;

endpackage

`default_nettype wire

//--- source/pixelGen.sv
/*
 Tile test pattern over the active area, one pixel per cycle while the FIFO
 is not full. mapXSize and mapYSize must be at least 1.
*/
`timescale 1ns/1ns
`default_nettype none

module pixelGen
	import videoPkg::*;
#(
	parameter int pHWidth = hWidth,
	parameter int pVWidth = vWidth
)(
	input  wire logic       iVideoClk,
	input  wire logic       rstN,
	input  wire videoTiming timing,
	input  wire logic [7:0] mapXSize,
	input  wire logic [7:0] mapYSize,
	input  wire logic       full,
	output rgbPixel         pixel,
	output logic            pixelWe
);

	// Raster position and tile tracking
	logic [pHWidth-1:0] x;
	logic [pVWidth-1:0] y;
	logic [7:0]         xInTile;
	logic [7:0]         yInTile;
	logic [pHWidth-1:0] tileCol;
	logic [pVWidth-1:0] tileRow;
	logic               run;

	// Last positions of line, frame and tile
	logic [pHWidth-1:0] lastX;
	logic [pVWidth-1:0] lastY;

	assign lastX = pHWidth'(timing.hDisplay - 1'b1);
	assign lastY = pVWidth'(timing.vDisplay - 1'b1);

	// Writes start one cycle after reset release
	assign pixelWe = run && !full;

	// Colour from tile indices and position
	assign pixel.red   = tileCol[3:0];
	assign pixel.green = tileRow[3:0];
	assign pixel.blue  = x[3:0] ^ y[3:0];

	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			run     <= 1'b0;
			x       <= '0;
			y       <= '0;
			xInTile <= '0;
			yInTile <= '0;
			tileCol <= '0;
			tileRow <= '0;
		end
		else
		begin
			run <= 1'b1;
			// Position held while the FIFO is full
			if (pixelWe)
			begin
				if (x == lastX)
				begin
					x       <= '0;
					xInTile <= '0;
					tileCol <= '0;
					if (y == lastY)
					begin
						y       <= '0;
						yInTile <= '0;
						tileRow <= '0;
					end
					else
					begin
						y <= y + 1'b1;
						if (yInTile == mapYSize - 8'd1)
						begin
							yInTile <= '0;
							tileRow <= tileRow + 1'b1;
						end
						else
							yInTile <= yInTile + 8'd1;
					end
				end
				else
				begin
					x <= x + 1'b1;
					if (xInTile == mapXSize - 8'd1)
					begin
						xInTile <= '0;
						tileCol <= tileCol + 1'b1;
					end
					else
						xInTile <= xInTile + 8'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/pixelFifo.sv
/*
 Synchronous pixel FIFO, depth a power of two. Read data appears one cycle
 after re; an empty read returns zero and latches underflow until reset.
*/
`timescale 1ns/1ns
`default_nettype none

module pixelFifo
	import videoPkg::*;
#(
	parameter int pFifoDepth = 32
)(
	input  wire logic    iVideoClk,
	input  wire logic    rstN,
	input  wire rgbPixel wrPixel,
	input  wire logic    we,
	input  wire logic    re,
	output rgbPixel      rdPixel,
	output logic         full,
	output logic         underflow
);

	localparam int lpAdrsWidth = $clog2(pFifoDepth);

	rgbPixel                mem [pFifoDepth];
	logic [lpAdrsWidth-1:0] wrPtr;
	logic [lpAdrsWidth-1:0] rdPtr;
	logic [lpAdrsWidth:0]   count;
	logic                   empty;
	logic                   wrOk;
	logic                   rdOk;

	assign full  = count == (lpAdrsWidth+1)'(pFifoDepth);
	assign empty = count == '0;
	// Write while full is dropped
	assign wrOk  = we && !full;
	assign rdOk  = re && !empty;

	//------------------------------------------------------------
	// Pointers, occupancy, sticky underflow
	//------------------------------------------------------------
	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			count     <= '0;
			underflow <= 1'b0;
		end
		else
		begin
			// Pointers wrap on their own, depth is 2**n
			if (wrOk)
				wrPtr <= wrPtr + 1'b1;
			if (rdOk)
				rdPtr <= rdPtr + 1'b1;
			case ({wrOk, rdOk})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (re && empty)
				underflow <= 1'b1;
		end
	end

	// Storage and registered read port
	always_ff @(posedge iVideoClk)
	begin
		if (wrOk)
			mem[wrPtr] <= wrPixel;
		if (re)
			rdPixel <= empty ? '0 : mem[rdPtr];
	end

	// Producer honours full
	assert property (@(posedge iVideoClk) disable iff (!rstN) !(we && full))
		else $error("pixelFifo: write while full");

	// Display timing leaves enough blanking to prefill
	assert property (@(posedge iVideoClk) disable iff (!rstN) !(re && empty))
		else $error("pixelFifo: read while empty");

endmodule

`default_nettype wire

//--- source/syncGen.sv
/*
 Raster counters and registered sync outputs, one cycle behind the counters.
 Starts on line vDisplay so the FIFO fills during the first blanking.
*/
`timescale 1ns/1ns
`default_nettype none

module syncGen
	import videoPkg::*;
#(
	parameter int pHWidth = hWidth,
	parameter int pVWidth = vWidth
)(
	input  wire logic       iVideoClk,
	input  wire logic       rstN,
	input  wire videoTiming timing,
	output logic            hSync,
	output logic            vSync,
	output logic            de,
	output logic            fe
);

	logic [pHWidth-1:0] hCnt;
	logic [pVWidth-1:0] vCnt;
	logic [pVWidth-1:0] vNow;
	logic               firstCycle;
	logic               hEnd;
	logic               vEnd;

	// Timing fields at counter width
	logic [pHWidth-1:0] hDisp;
	logic [pHWidth-1:0] hSs;
	logic [pHWidth-1:0] hSe;
	logic [pHWidth-1:0] hLast;
	logic [pVWidth-1:0] vDisp;
	logic [pVWidth-1:0] vSs;
	logic [pVWidth-1:0] vSe;
	logic [pVWidth-1:0] vLast;

	assign hDisp = pHWidth'(timing.hDisplay);
	assign hSs   = pHWidth'(timing.hSyncStart);
	assign hSe   = pHWidth'(timing.hSyncEnd);
	assign hLast = pHWidth'(timing.hMax);
	assign vDisp = pVWidth'(timing.vDisplay);
	assign vSs   = pVWidth'(timing.vSyncStart);
	assign vSe   = pVWidth'(timing.vSyncEnd);
	assign vLast = pVWidth'(timing.vMax);

	// First cycle after reset sits on the first blanking line
	assign vNow = firstCycle ? vDisp : vCnt;
	assign hEnd = hCnt == hLast;
	assign vEnd = vNow == vLast;

	//------------------------------------------------------------
	// Horizontal and vertical counters
	//------------------------------------------------------------
	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hCnt       <= '0;
			vCnt       <= '0;
			firstCycle <= 1'b1;
		end
		else
		begin
			firstCycle <= 1'b0;
			if (hEnd)
			begin
				hCnt <= '0;
				vCnt <= vEnd ? '0 : vNow + 1'b1;
			end
			else
			begin
				hCnt <= hCnt + 1'b1;
				vCnt <= vNow;
			end
		end
	end

	//------------------------------------------------------------
	// Registered sync, active high
	//------------------------------------------------------------
	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hSync <= 1'b0;
			vSync <= 1'b0;
			de    <= 1'b0;
			fe    <= 1'b0;
		end
		else
		begin
			hSync <= (hCnt >= hSs) && (hCnt < hSe);
			vSync <= (vNow >= vSs) && (vNow < vSe);
			de    <= (hCnt < hDisp) && (vNow < vDisp);
			// Frame end at the last counter state
			fe    <= hEnd && vEnd;
		end
	end

	// Line sync lies in the blanking
	assert property (@(posedge iVideoClk) disable iff (!rstN) !(de && hSync))
		else $error("syncGen: de overlaps hSync");

endmodule

`default_nettype wire

//--- source/tftOut.sv
/*
 TFT output stage. Sync is delayed one cycle to line up with the FIFO read;
 colour is forced to zero outside active video.
*/
`timescale 1ns/1ns
`default_nettype none

module tftOut
	import videoPkg::*;
(
	input  wire logic       iVideoClk,
	input  wire logic       rstN,
	input  wire rgbPixel    rdPixel,
	input  wire logic       hSync,
	input  wire logic       vSync,
	input  wire logic       de,
	input  wire logic [7:0] blDuty,
	output tftPins          pins
);

	// Alignment stage for the FIFO read latency
	logic hSyncD;
	logic vSyncD;
	logic deD;

	// Backlight PWM
	logic [7:0] pwmCnt;
	logic       blOn;

	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hSyncD <= 1'b0;
			vSyncD <= 1'b0;
			deD    <= 1'b0;
		end
		else
		begin
			hSyncD <= hSync;
			vSyncD <= vSync;
			deD    <= de;
		end
	end

	//------------------------------------------------------------
	// 256-cycle PWM, high for blDuty counts
	//------------------------------------------------------------
	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			pwmCnt <= '0;
			blOn   <= 1'b0;
		end
		else
		begin
			pwmCnt <= pwmCnt + 8'd1;
			blOn   <= pwmCnt < blDuty;
		end
	end

	// rdPixel is already the FIFO output register, same stage as deD
	always_comb
	begin
		pins.colorR    = deD ? rdPixel.red : 4'd0;
		pins.colorG    = deD ? rdPixel.green : 4'd0;
		pins.colorB    = deD ? rdPixel.blue : 4'd0;
		pins.hSync     = hSyncD;
		pins.vSync     = vSyncD;
		pins.de        = deD;
		pins.backLight = blOn;
	end

endmodule

`default_nettype wire

//--- source/videoTxUnit.sv
/*
 Video transmit path, single clock. Configuration inputs must stay static
 while rstN is high; blanking must be long enough to prefill the FIFO.
*/
`timescale 1ns/1ns
`default_nettype none

module videoTxUnit
	import videoPkg::*;
#(
	parameter int pFifoDepth = 32,
	parameter int pHWidth    = hWidth,
	parameter int pVWidth    = vWidth
)(
	input  wire logic       iVideoClk,
	input  wire logic       rstN,
	input  wire videoTiming timing,
	input  wire logic [7:0] mapXSize,
	input  wire logic [7:0] mapYSize,
	input  wire logic [7:0] blDuty,
	output tftPins          pins,
	output logic            fe,
	output logic            underflow
);

	// Producer to FIFO
	rgbPixel pixel;
	logic    pixelWe;
	logic    full;

	// FIFO and sync to output stage
	rgbPixel rdPixel;
	logic    hSync;
	logic    vSync;
	logic    de;

	pixelGen #(
		.pHWidth   (pHWidth),
		.pVWidth   (pVWidth)
	) uPixelGen (
		.iVideoClk (iVideoClk),
		.rstN      (rstN),
		.timing    (timing),
		.mapXSize  (mapXSize),
		.mapYSize  (mapYSize),
		.full      (full),
		.pixel     (pixel),
		.pixelWe   (pixelWe)
	);

	// de pops one pixel per active cycle
	pixelFifo #(
		.pFifoDepth (pFifoDepth)
	) uPixelFifo (
		.iVideoClk  (iVideoClk),
		.rstN       (rstN),
		.wrPixel    (pixel),
		.we         (pixelWe),
		.re         (de),
		.rdPixel    (rdPixel),
		.full       (full),
		.underflow  (underflow)
	);

	syncGen #(
		.pHWidth   (pHWidth),
		.pVWidth   (pVWidth)
	) uSyncGen (
		.iVideoClk (iVideoClk),
		.rstN      (rstN),
		.timing    (timing),
		.hSync     (hSync),
		.vSync     (vSync),
		.de        (de),
		.fe        (fe)
	);

	tftOut uTftOut (
		.iVideoClk (iVideoClk),
		.rstN      (rstN),
		.rdPixel   (rdPixel),
		.hSync     (hSync),
		.vSync     (vSync),
		.de        (de),
		.blDuty    (blDuty),
		.pins      (pins)
	);

endmodule

`default_nettype wire

//--- tb/clkGen.sv
/*
 Testbench clock, 4 ns period, with a reset held low for pResetCycles
 rising edges at start-up and again after each rstReq.
*/
`timescale 1ns/1ns
`default_nettype none

module clkGen #(
	parameter int pResetCycles = 10
)(
	input  wire logic rstReq,
	output logic      clk,
	output logic      rstN
);

	int rstCnt;

	initial
	begin
		clk    = 1'b0;
		rstN   = 1'b0;
		rstCnt = pResetCycles;
	end

	always #2 clk = ~clk;

	// Reset released on the edge that counts the last cycle
	always @(posedge clk)
	begin
		if (rstReq)
		begin
			rstCnt <= pResetCycles;
			rstN   <= 1'b0;
		end
		else if (rstCnt > 1)
			rstCnt <= rstCnt - 1;
		else
		begin
			rstCnt <= 0;
			rstN   <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- tb/videoTxTb.sv
/*
 Testbench for the video transmit path. Three random configurations, each
 run for the start-up blanking plus two full frames; outputs sampled at negedge.
*/
`timescale 1ns/1ns
`default_nettype none

module videoTxTb
	import videoPkg::*;
();

	// DUT inputs and outputs
	logic       iVideoClk;
	logic       rstN;
	logic       rstReq;
	videoTiming timing;
	logic [7:0] mapXSize;
	logic [7:0] mapYSize;
	logic [7:0] blDuty;
	tftPins     pins;
	logic       fe;
	logic       underflow;

	// Drawn configurations
	videoTiming cfgTiming [3];
	logic [7:0] cfgMapX [3];
	logic [7:0] cfgMapY [3];
	logic [7:0] cfgDuty [3];

	int seed;
	int cycles;
	int cycleLimit;
	int pixelErrs;
	int levelErrs;
	int countErrs;

	// Raster model state
	int         mx;
	int         my;
	int         pixCnt;
	int         deCycles;
	int         lines;
	int         sinceDeFall;
	int         hsWidth;
	int         vsWidth;
	int         feGap;
	int         feCount;
	int         blSum;
	int         blSamples;
	logic [7:0] blIdx;
	logic       blHist [256];
	logic       lineActive;
	logic       dePrev;
	logic       hsPrev;
	logic       vsPrev;
	rgbPixel    colour;

	clkGen #(
		.pResetCycles (10)
	) uClkGen (
		.rstReq (rstReq),
		.clk    (iVideoClk),
		.rstN   (rstN)
	);

	videoTxUnit #(
		.pFifoDepth (32)
	) u_dut (
		.iVideoClk (iVideoClk),
		.rstN      (rstN),
		.timing    (timing),
		.mapXSize  (mapXSize),
		.mapYSize  (mapYSize),
		.blDuty    (blDuty),
		.pins      (pins),
		.fe        (fe),
		.underflow (underflow)
	);

	//------------------------------------------------------------
	// Compare tasks and model helpers
	//------------------------------------------------------------
	task automatic checkPixel(input string name, input rgbPixel actual, input rgbPixel expected);
		if (actual !== expected)
		begin
			pixelErrs++;
			$display("mismatch %s: got 0x%h expected 0x%h at (%0d,%0d)",
				name, actual, expected, mx, my);
		end
	endtask

	task automatic checkTiming(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			levelErrs++;
			$display("mismatch %s: got 0x%h expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic checkCount(input string name, input int actual, input int expected);
		if (actual != expected)
		begin
			countErrs++;
			$display("mismatch %s: got 0x%0h expected 0x%0h", name, actual, expected);
		end
	endtask

	function automatic int randRange(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	// Tile rule: tile column, tile row, x xor y
	function automatic rgbPixel tilePixel(input int px, input int py);
		rgbPixel p;
		p.red   = 4'((px / int'(mapXSize)) % 16);
		p.green = 4'((py / int'(mapYSize)) % 16);
		p.blue  = 4'(px % 16) ^ 4'(py % 16);
		return p;
	endfunction

	// Sync inside blanking, 40+ blanking cycles per line, 2+ blanking lines
	task automatic drawConfig(input int idx);
		int hd;
		int hs;
		int he;
		int vd;
		int vs;
		int ve;
		hd = randRange(8, 40);
		hs = hd + randRange(1, 8);
		he = hs + randRange(2, 9);
		vd = randRange(4, 12);
		vs = vd + randRange(0, 1);
		ve = vs + randRange(1, 2);
		cfgTiming[idx].hDisplay   = 11'(hd);
		cfgTiming[idx].hSyncStart = 11'(hs);
		cfgTiming[idx].hSyncEnd   = 11'(he);
		cfgTiming[idx].hMax       = 11'(hd + 40 + randRange(0, 7));
		cfgTiming[idx].vDisplay   = 11'(vd);
		cfgTiming[idx].vSyncStart = 11'(vs);
		cfgTiming[idx].vSyncEnd   = 11'(ve);
		cfgTiming[idx].vMax       = 11'(ve + randRange(0, 2));
		cfgMapX[idx] = 8'(randRange(1, 8));
		cfgMapY[idx] = 8'(randRange(1, 8));
		cfgDuty[idx] = 8'(randRange(0, 255));
	endtask

	//------------------------------------------------------------
	// Output monitor, mid-cycle
	//------------------------------------------------------------
	always @(negedge iVideoClk)
	begin
		if (!rstN)
		begin
			mx          = 0;
			my          = 0;
			pixCnt      = 0;
			deCycles    = 0;
			lines       = 0;
			sinceDeFall = 0;
			hsWidth     = 0;
			vsWidth     = 0;
			feGap       = 0;
			feCount     = 0;
			blSum       = 0;
			blSamples   = 0;
			blIdx       = 8'd0;
			lineActive  = 1'b0;
			dePrev      = 1'b0;
			hsPrev      = 1'b0;
			vsPrev      = 1'b0;
		end
		else
		begin
			colour = {pins.colorR, pins.colorG, pins.colorB};
			if (pins.de)
			begin
				checkPixel("colour", colour, tilePixel(mx, my));
				checkTiming("hSync", pins.hSync, 1'b0);
				deCycles++;
				pixCnt++;
				mx++;
				if (mx == int'(timing.hDisplay))
				begin
					mx = 0;
					my = (my + 1 == int'(timing.vDisplay)) ? 0 : my + 1;
				end
			end
			else
			begin
				// Blanked colour
				checkPixel("colour", colour, '0);
				if (dePrev)
				begin
					checkCount("deCycles", deCycles, int'(timing.hDisplay));
					deCycles    = 0;
					lines++;
					sinceDeFall = 0;
					lineActive  = 1'b1;
				end
				else
					sinceDeFall++;
			end
			// hSync delay after the end of an active line
			if (pins.hSync && !hsPrev && lineActive)
			begin
				checkCount("hSyncDelay", sinceDeFall,
					int'(timing.hSyncStart) - int'(timing.hDisplay));
				lineActive = 1'b0;
			end
			if (pins.hSync)
				hsWidth++;
			else if (hsPrev)
			begin
				checkCount("hSyncWidth", hsWidth,
					int'(timing.hSyncEnd) - int'(timing.hSyncStart));
				hsWidth = 0;
			end
			// vSync width in cycles, whole lines
			if (pins.vSync)
				vsWidth++;
			else if (vsPrev)
			begin
				checkCount("vSyncWidth", vsWidth,
					(int'(timing.vSyncEnd) - int'(timing.vSyncStart)) * (int'(timing.hMax) + 1));
				vsWidth = 0;
			end
			// First fe closes the start-up blanking, no active lines
			feGap++;
			if (fe)
			begin
				if (feCount > 0)
					checkCount("feInterval", feGap,
						(int'(timing.hMax) + 1) * (int'(timing.vMax) + 1));
				checkCount("activeLines", lines, (feCount == 0) ? 0 : int'(timing.vDisplay));
				lines = 0;
				feGap = 0;
				feCount++;
			end
			// Sliding 256-cycle backlight window
			if (blSamples >= 256)
				blSum = blSum - int'(blHist[blIdx]);
			blHist[blIdx] = pins.backLight;
			blSum         = blSum + int'(pins.backLight);
			blIdx         = blIdx + 8'd1;
			blSamples++;
			if (blSamples >= 256)
				checkCount("backLightHigh", blSum, int'(blDuty));
			checkTiming("underflow", underflow, 1'b0);
			dePrev = pins.de;
			hsPrev = pins.hSync;
			vsPrev = pins.vSync;
		end
	end

	// Watchdog
	always @(posedge iVideoClk)
	begin
		cycles++;
		if (cycles > cycleLimit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display(">>> FAIL");
			$finish;
		end
	end

	//------------------------------------------------------------
	// Stimulus
	//------------------------------------------------------------
	initial
	begin
		int i;
		int total;
		seed      = 32'h4ea3;
		cycles    = 0;
		pixelErrs = 0;
		levelErrs = 0;
		countErrs = 0;
		total     = 0;
		for (i = 0; i < 3; i++)
			drawConfig(i);
		// Start-up blanking plus two frames is under three frames
		for (i = 0; i < 3; i++)
			total += 3 * (int'(cfgTiming[i].hMax) + 1) * (int'(cfgTiming[i].vMax) + 1) + 13;
		cycleLimit = total + total / 2;
		rstReq   <= 1'b0;
		timing   <= '0;
		mapXSize <= 8'd1;
		mapYSize <= 8'd1;
		blDuty   <= 8'd0;
		for (i = 0; i < 3; i++)
		begin
			@(posedge iVideoClk);
			rstReq <= 1'b1;
			@(posedge iVideoClk);
			rstReq <= 1'b0;
			// Configuration changes only inside reset
			@(posedge iVideoClk);
			timing   <= cfgTiming[i];
			mapXSize <= cfgMapX[i];
			mapYSize <= cfgMapY[i];
			blDuty   <= cfgDuty[i];
			while (!rstN)
				@(posedge iVideoClk);
			while (feCount < 3)
				@(posedge iVideoClk);
			checkCount("pixelCount", pixCnt,
				2 * int'(cfgTiming[i].hDisplay) * int'(cfgTiming[i].vDisplay));
		end
		$display("errors: pixel=%0d level=%0d count=%0d", pixelErrs, levelErrs, countErrs);
		if (pixelErrs + levelErrs + countErrs == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
source/videoPkg.sv
source/pixelGen.sv
source/pixelFifo.sv
source/syncGen.sv
source/tftOut.sv
source/videoTxUnit.sv
tb/clkGen.sv
tb/videoTxTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= videoTxTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q -x '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
